/* dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ======================================================================
// Cache geometry
// ======================================================================

// Address and data word width
`define DC_XLEN 32

// One line is four words
`define DC_LINE_BITS 128

// Ways per set
`define DC_NUM_WAY 4

// Sets in the cache, one index per set
`define DC_NUM_SET 8

`endif

/* dcache_pkg.sv */
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

  // Address split is tag, then index, then byte offset in the line
  localparam int unsigned OFF_W = $clog2(`DC_LINE_BITS / 8);
  localparam int unsigned IDX_W = $clog2(`DC_NUM_SET);
  localparam int unsigned TAG_W = `DC_XLEN - IDX_W - OFF_W;

  typedef logic [`DC_XLEN-1:0]      word_t;
  typedef logic [`DC_LINE_BITS-1:0] line_t;
  typedef logic [`DC_XLEN-1:0]      addr_t;
  typedef logic [IDX_W-1:0]         idx_t;
  typedef logic [TAG_W-1:0]         tag_t;
  typedef logic [OFF_W-1:0]         off_t;
  typedef logic [`DC_NUM_WAY-1:0]   way_vec_t;

  // Three tree bits cover four ways
  typedef logic [`DC_NUM_WAY-2:0]   plru_node_t;

  typedef enum logic [1:0] {
    SZ_BYTE,
    SZ_HALF,
    SZ_WORD
  } req_size_e;

  typedef enum logic [2:0] {
    ST_INIT,
    ST_RUN,
    ST_WB_REQ,
    ST_WB_WAIT,
    ST_FILL_REQ,
    ST_FILL_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

/* dcache_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_sram #(
  parameter int unsigned WIDTH = 8
) (
  input  wire logic             clk_i,
  input  wire dcache_pkg::idx_t addr_i,
  input  wire logic             wr_en_i,
  input  wire logic [WIDTH-1:0] wr_data_i,
  output logic      [WIDTH-1:0] rd_data_o
);

  // One entry per set
  logic [WIDTH-1:0] mem_q [`DC_NUM_SET];

  // Registered read; a write shows up on the read port at once
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[addr_i] <= wr_data_i;
      rd_data_o     <= wr_data_i;
    end else begin
      rd_data_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

/* dcache_plru.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_plru (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire dcache_pkg::idx_t     idx_i,
  input  wire dcache_pkg::way_vec_t valid_vec_i,
  input  wire logic                 touch_i,
  input  wire dcache_pkg::way_vec_t touch_way_i,
  input  wire logic                 clear_i,
  output dcache_pkg::way_vec_t      victim_o
);
  import dcache_pkg::*;

  // Tree bits per set
  // bit 0 root, 1 picks the upper pair
  // bit 1 lower pair, 1 picks way 1
  // bit 2 upper pair, 1 picks way 3
  plru_node_t nodes_q [`DC_NUM_SET];
  plru_node_t node;
  plru_node_t node_upd;
  way_vec_t   tree_way;
  way_vec_t   inv_way;

  always_comb begin
    node = nodes_q[idx_i];

    // Follow the tree down to one way
    tree_way = '0;
    if (node[0]) begin
      tree_way[node[2] ? 3 : 2] = 1'b1;
    end else begin
      tree_way[node[1] ? 1 : 0] = 1'b1;
    end

    // Lowest invalid way wins over the tree
    inv_way = '0;
    for (int w = `DC_NUM_WAY - 1; w >= 0; w--) begin
      if (!valid_vec_i[w]) begin
        inv_way = way_vec_t'(1) << w;
      end
    end
    victim_o = (|inv_way) ? inv_way : tree_way;

    // Point the path away from the used way
    node_upd = node;
    if (touch_way_i[0] || touch_way_i[1]) begin
      node_upd[0] = 1'b1;
      node_upd[1] = touch_way_i[0];
    end else begin
      node_upd[0] = 1'b0;
      node_upd[2] = touch_way_i[2];
    end
  end

  // ======================================================================
  // Node storage
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < `DC_NUM_SET; s++) begin
        nodes_q[s] <= '0;
      end
    end else if (clear_i) begin
      nodes_q[idx_i] <= '0;
    end else if (touch_i) begin
      nodes_q[idx_i] <= node_upd;
    end
  end

endmodule

`default_nettype wire

/* dcache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_lookup (
  input  wire logic                  clk_i,
  input  wire dcache_pkg::idx_t      idx_i,
  input  wire dcache_pkg::tag_t      tag_i,
  input  wire dcache_pkg::off_t      offset_i,
  input  wire dcache_pkg::req_size_e size_i,
  input  wire logic                  we_i,
  input  wire dcache_pkg::word_t     wdata_i,
  input  wire dcache_pkg::line_t     fill_line_i,
  input  wire logic                  use_fill_i,
  input  wire dcache_pkg::way_vec_t  tag_we_i,
  input  wire logic                  tag_clear_i,
  input  wire dcache_pkg::way_vec_t  data_we_i,
  input  wire dcache_pkg::way_vec_t  victim_i,
  output dcache_pkg::way_vec_t       hit_vec_o,
  output dcache_pkg::way_vec_t       valid_vec_o,
  output dcache_pkg::word_t          word_o,
  output dcache_pkg::tag_t           victim_tag_o,
  output dcache_pkg::line_t          victim_line_o
);
  import dcache_pkg::*;

  // Tag entry is {valid, tag}
  logic [TAG_W:0] tag_rd [`DC_NUM_WAY];
  logic [TAG_W:0] tag_wdata;
  line_t          line_rd [`DC_NUM_WAY];
  line_t          base_line;
  line_t          merged;

  // Sweep writes an invalid zero tag
  assign tag_wdata = tag_clear_i ? '0 : {1'b1, tag_i};

  // ======================================================================
  // Tag and data ways
  // ======================================================================
  for (genvar w = 0; w < `DC_NUM_WAY; w++) begin : g_way
    dcache_sram #(
      .WIDTH(TAG_W + 1)
    ) u_tag (
      .clk_i    (clk_i),
      .addr_i   (idx_i),
      .wr_en_i  (tag_we_i[w]),
      .wr_data_i(tag_wdata),
      .rd_data_o(tag_rd[w])
    );

    dcache_sram #(
      .WIDTH(`DC_LINE_BITS)
    ) u_data (
      .clk_i    (clk_i),
      .addr_i   (idx_i),
      .wr_en_i  (data_we_i[w]),
      .wr_data_i(merged),
      .rd_data_o(line_rd[w])
    );
  end

  // Tag compare against the held request
  always_comb begin
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      valid_vec_o[w] = tag_rd[w][TAG_W];
      hit_vec_o[w]   = valid_vec_o[w] && (tag_rd[w][TAG_W-1:0] == tag_i);
    end
  end

  // Line source, store merge and response word
  always_comb begin
    base_line = '0;
    if (use_fill_i) begin
      base_line = fill_line_i;
    end else begin
      for (int w = 0; w < `DC_NUM_WAY; w++) begin
        if (hit_vec_o[w]) begin
          base_line = line_rd[w];
        end
      end
    end

    merged = base_line;
    if (we_i) begin
      unique case (size_i)
        SZ_BYTE: merged[offset_i*8 +: 8] = wdata_i[7:0];
        SZ_HALF: merged[offset_i[OFF_W-1:1]*16 +: 16] = wdata_i[15:0];
        default: merged[offset_i[OFF_W-1:2]*32 +: 32] = wdata_i;
      endcase
    end

    // Aligned word holding the address
    word_o = merged[offset_i[OFF_W-1:2]*32 +: 32];
  end

  // Victim tag and line for write-back
  always_comb begin
    victim_tag_o  = '0;
    victim_line_o = '0;
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (victim_i[w]) begin
        victim_tag_o  = tag_rd[w][TAG_W-1:0];
        victim_line_o = line_rd[w];
      end
    end
  end

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // CPU side
  input  wire logic                  req_valid_i,
  input  wire dcache_pkg::addr_t     req_addr_i,
  input  wire logic                  req_we_i,
  input  wire dcache_pkg::req_size_e req_size_i,
  input  wire dcache_pkg::word_t     req_wdata_i,
  output logic                       req_ready_o,
  output logic                       res_valid_o,
  output dcache_pkg::word_t          res_data_o,
  output logic                       res_miss_o,
  // Memory side
  output logic                       mem_req_valid_o,
  output logic                       mem_req_we_o,
  output dcache_pkg::addr_t          mem_req_addr_o,
  output dcache_pkg::line_t          mem_req_wdata_o,
  input  wire logic                  mem_req_ready_i,
  input  wire logic                  mem_res_valid_i,
  // Lookup control
  output dcache_pkg::idx_t           arr_idx_o,
  output dcache_pkg::tag_t           req_tag_o,
  output dcache_pkg::off_t           req_off_o,
  output dcache_pkg::req_size_e      req_size_o,
  output dcache_pkg::word_t          req_wdata_o,
  output logic                       req_we_o,
  output logic                       use_fill_o,
  output dcache_pkg::way_vec_t       tag_we_o,
  output logic                       tag_clear_o,
  output dcache_pkg::way_vec_t       data_we_o,
  // Replacement control
  output dcache_pkg::idx_t           plru_idx_o,
  output logic                       touch_o,
  output dcache_pkg::way_vec_t       touch_way_o,
  output logic                       clear_o,
  // Lookup and replacement results
  input  wire dcache_pkg::way_vec_t  hit_vec_i,
  input  wire dcache_pkg::way_vec_t  valid_vec_i,
  input  wire dcache_pkg::word_t     word_i,
  input  wire dcache_pkg::way_vec_t  victim_i,
  input  wire dcache_pkg::tag_t      victim_tag_i,
  input  wire dcache_pkg::line_t     victim_line_i
);
  import dcache_pkg::*;

  ctrl_state_e state_q, state_d;
  idx_t        sweep_q;

  // Lookup stage request
  logic        req_valid_q;
  logic        replay_q;
  addr_t       req_addr_q;
  logic        req_we_q;
  req_size_e   req_size_q;
  word_t       req_wdata_q;

  // Dirty bits per set, kept in flops
  way_vec_t    dirty_q [`DC_NUM_SET];

  // Victim captured at the miss
  way_vec_t    victim_way_q;
  tag_t        victim_tag_q;
  line_t       victim_line_q;

  idx_t        req_idx;
  idx_t        in_idx;
  logic        lookup;
  logic        hit;
  logic        miss;
  logic        store_hit;
  logic        fill_done;
  logic        arr_write;
  logic        accept;
  logic        wb_need;

  assign req_idx = req_addr_q[IDX_W+OFF_W-1:OFF_W];
  assign in_idx  = req_addr_i[IDX_W+OFF_W-1:OFF_W];

  // Tag compare is valid one cycle after acceptance, unless replayed
  assign lookup    = (state_q == ST_RUN) && req_valid_q && !replay_q;
  assign hit       = lookup && (|hit_vec_i);
  assign miss      = lookup && !(|hit_vec_i);
  assign store_hit = hit && req_we_q;
  assign fill_done = (state_q == ST_FILL_WAIT) && mem_res_valid_i;
  assign arr_write = store_hit || fill_done;
  assign wb_need   = |(victim_i & valid_vec_i & dirty_q[req_idx]);

  assign req_ready_o = ((state_q == ST_RUN) && !miss && !replay_q) || fill_done;
  assign accept      = req_valid_i && req_ready_o;

  // Array port goes to the writer first, else to the new request
  always_comb begin
    if (state_q == ST_INIT) begin
      arr_idx_o = sweep_q;
    end else if (accept && !arr_write) begin
      arr_idx_o = in_idx;
    end else begin
      arr_idx_o = req_idx;
    end
  end

  // ======================================================================
  // Request register
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
      replay_q    <= 1'b0;
    end else begin
      if (accept) begin
        req_valid_q <= 1'b1;
      end else if (hit || fill_done) begin
        req_valid_q <= 1'b0;
      end
      // Lost its read to a write elsewhere, read again
      replay_q <= accept && arr_write && (in_idx != req_idx);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q  <= req_addr_i;
      req_we_q    <= req_we_i;
      req_size_q  <= req_size_i;
      req_wdata_q <= req_wdata_i;
    end
  end

  // ======================================================================
  // Sweep and miss FSM
  // ======================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_INIT;
      sweep_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_INIT) begin
        sweep_q <= sweep_q + 1'b1;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_INIT: begin
        if (sweep_q == idx_t'(`DC_NUM_SET - 1)) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        // Dirty victim goes out before the fill
        if (miss) begin
          state_d = wb_need ? ST_WB_REQ : ST_FILL_REQ;
        end
      end
      ST_WB_REQ: begin
        if (mem_req_ready_i) begin
          state_d = ST_WB_WAIT;
        end
      end
      ST_WB_WAIT: begin
        if (mem_res_valid_i) begin
          state_d = ST_FILL_REQ;
        end
      end
      ST_FILL_REQ: begin
        if (mem_req_ready_i) begin
          state_d = ST_FILL_WAIT;
        end
      end
      ST_FILL_WAIT: begin
        if (mem_res_valid_i) begin
          state_d = ST_RUN;
        end
      end
      default: state_d = ST_INIT;
    endcase
  end

  // Victim latch at the tag compare
  always_ff @(posedge clk_i) begin
    if (miss) begin
      victim_way_q  <= victim_i;
      victim_tag_q  <= victim_tag_i;
      victim_line_q <= victim_line_i;
    end
  end

  // Set on a store, cleared when a load fills the way
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < `DC_NUM_SET; s++) begin
        dirty_q[s] <= '0;
      end
    end else if (store_hit) begin
      dirty_q[req_idx] <= dirty_q[req_idx] | hit_vec_i;
    end else if (fill_done) begin
      dirty_q[req_idx] <= req_we_q ? (dirty_q[req_idx] | victim_way_q)
                                   : (dirty_q[req_idx] & ~victim_way_q);
    end
  end

  // ======================================================================
  // Memory port and CPU response
  // ======================================================================
  assign mem_req_valid_o = (state_q == ST_WB_REQ) || (state_q == ST_FILL_REQ);
  assign mem_req_we_o    = (state_q == ST_WB_REQ);
  assign mem_req_addr_o  = (state_q == ST_WB_REQ) ?
                           {victim_tag_q, req_idx, {OFF_W{1'b0}}} :
                           {req_addr_q[`DC_XLEN-1:OFF_W], {OFF_W{1'b0}}};
  assign mem_req_wdata_o = victim_line_q;

  assign res_valid_o = hit || fill_done;
  assign res_miss_o  = fill_done;
  assign res_data_o  = word_i;

  // Lookup side
  assign req_tag_o   = req_addr_q[`DC_XLEN-1:IDX_W+OFF_W];
  assign req_off_o   = req_addr_q[OFF_W-1:0];
  assign req_size_o  = req_size_q;
  assign req_wdata_o = req_wdata_q;
  assign req_we_o    = req_we_q;
  assign use_fill_o  = (state_q == ST_FILL_WAIT);
  assign tag_clear_o = (state_q == ST_INIT);
  assign tag_we_o    = (state_q == ST_INIT) ? '1 : (fill_done ? victim_way_q : '0);
  assign data_we_o   = store_hit ? hit_vec_i : (fill_done ? victim_way_q : '0);

  // Replacement side
  assign plru_idx_o  = (state_q == ST_INIT) ? sweep_q : req_idx;
  assign touch_o     = hit || fill_done;
  assign touch_way_o = hit ? hit_vec_i : victim_way_q;
  assign clear_o     = (state_q == ST_INIT);

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  req_valid_i,
  input  wire dcache_pkg::addr_t     req_addr_i,
  input  wire logic                  req_we_i,
  input  wire dcache_pkg::req_size_e req_size_i,
  input  wire dcache_pkg::word_t     req_wdata_i,
  output logic                       req_ready_o,
  output logic                       res_valid_o,
  output dcache_pkg::word_t          res_data_o,
  output logic                       res_miss_o,
  output logic                       mem_req_valid_o,
  output logic                       mem_req_we_o,
  output dcache_pkg::addr_t          mem_req_addr_o,
  output dcache_pkg::line_t          mem_req_wdata_o,
  input  wire logic                  mem_req_ready_i,
  input  wire logic                  mem_res_valid_i,
  input  wire dcache_pkg::line_t     mem_res_rdata_i
);
  import dcache_pkg::*;

  // Lookup controls
  idx_t      arr_idx;
  tag_t      req_tag;
  off_t      req_off;
  req_size_e req_size;
  word_t     req_wdata;
  logic      req_we;
  logic      use_fill;
  way_vec_t  tag_we;
  logic      tag_clear;
  way_vec_t  data_we;

  // Replacement controls
  idx_t      plru_idx;
  logic      touch;
  way_vec_t  touch_way;
  logic      plru_clear;

  // Results
  way_vec_t  hit_vec;
  way_vec_t  valid_vec;
  word_t     word;
  way_vec_t  victim;
  tag_t      victim_tag;
  line_t     victim_line;

  dcache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_wdata_i    (req_wdata_i),
    .req_ready_o    (req_ready_o),
    .res_valid_o    (res_valid_o),
    .res_data_o     (res_data_o),
    .res_miss_o     (res_miss_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_we_o   (mem_req_we_o),
    .mem_req_addr_o (mem_req_addr_o),
    .mem_req_wdata_o(mem_req_wdata_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_res_valid_i(mem_res_valid_i),
    .arr_idx_o      (arr_idx),
    .req_tag_o      (req_tag),
    .req_off_o      (req_off),
    .req_size_o     (req_size),
    .req_wdata_o    (req_wdata),
    .req_we_o       (req_we),
    .use_fill_o     (use_fill),
    .tag_we_o       (tag_we),
    .tag_clear_o    (tag_clear),
    .data_we_o      (data_we),
    .plru_idx_o     (plru_idx),
    .touch_o        (touch),
    .touch_way_o    (touch_way),
    .clear_o        (plru_clear),
    .hit_vec_i      (hit_vec),
    .valid_vec_i    (valid_vec),
    .word_i         (word),
    .victim_i       (victim),
    .victim_tag_i   (victim_tag),
    .victim_line_i  (victim_line)
  );

  // Fill data comes straight from memory
  dcache_lookup u_lookup (
    .clk_i        (clk_i),
    .idx_i        (arr_idx),
    .tag_i        (req_tag),
    .offset_i     (req_off),
    .size_i       (req_size),
    .we_i         (req_we),
    .wdata_i      (req_wdata),
    .fill_line_i  (mem_res_rdata_i),
    .use_fill_i   (use_fill),
    .tag_we_i     (tag_we),
    .tag_clear_i  (tag_clear),
    .data_we_i    (data_we),
    .victim_i     (victim),
    .hit_vec_o    (hit_vec),
    .valid_vec_o  (valid_vec),
    .word_o       (word),
    .victim_tag_o (victim_tag),
    .victim_line_o(victim_line)
  );

  dcache_plru u_plru (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .idx_i      (plru_idx),
    .valid_vec_i(valid_vec),
    .touch_i    (touch),
    .touch_way_i(touch_way),
    .clear_i    (plru_clear),
    .victim_o   (victim)
  );

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;
  import dcache_pkg::*;

  // Backing store word value is its address XOR this pattern
  localparam word_t MEM_PATTERN = 32'h5a5a0000;
  localparam int    MAX_ACC     = 64;
  localparam int    REQ_TIMEOUT = 50;
  localparam int    RSP_TIMEOUT = 200;

  typedef enum logic [1:0] {M_IDLE, M_ACCEPT, M_RESPOND} mem_phase_e;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  addr_t     req_addr_i;
  logic      req_we_i;
  req_size_e req_size_i;
  word_t     req_wdata_i;
  logic      req_ready_o;
  logic      res_valid_o;
  word_t     res_data_o;
  logic      res_miss_o;
  logic      mem_req_valid_o;
  logic      mem_req_we_o;
  addr_t     mem_req_addr_o;
  line_t     mem_req_wdata_o;
  logic      mem_req_ready_i;
  logic      mem_res_valid_i;
  line_t     mem_res_rdata_i;

  // Access list, {op, size, address, store data}
  logic [71:0] acc_mem [MAX_ACC];
  int          n_acc;

  // Memory model and its expected next requests
  word_t      mem_words [addr_t];
  logic [7:0] ref_bytes [addr_t];
  mem_phase_e mphase;
  int         mcount;
  logic       m_we;
  addr_t      m_addr;
  line_t      m_wdata;
  logic       exp_wb;
  logic       exp_fill;
  addr_t      exp_wb_addr;
  addr_t      exp_fill_addr;
  line_t      exp_wb_line;

  // Cache contents as the rules predict them
  logic       c_valid [`DC_NUM_SET][`DC_NUM_WAY];
  logic       c_dirty [`DC_NUM_SET][`DC_NUM_WAY];
  tag_t       c_tag   [`DC_NUM_SET][`DC_NUM_WAY];
  plru_node_t c_tree  [`DC_NUM_SET];

  dcache_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ======================================================================
  // Checks
  // ======================================================================
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) fail_now($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                                        $time, name, got, exp));
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) fail_now($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                                        $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) fail_now($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                                        $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("Mismatch at %0d ns: %s got %b expected %b",
                                        $time, name, got, exp));
  endtask

  // ======================================================================
  // Reference model
  // ======================================================================
  function automatic word_t mem_word(input addr_t a);
    if (mem_words.exists(a)) return mem_words[a];
    return a ^ MEM_PATTERN;
  endfunction

  function automatic line_t read_line(input addr_t a);
    line_t l;
    for (int w = 0; w < 4; w++) l[32*w +: 32] = mem_word(addr_t'(a + 4*w));
    return l;
  endfunction

  // Untouched bytes keep the initial memory pattern
  function automatic logic [7:0] ref_byte(input addr_t a);
    word_t w;
    w = {a[31:2], 2'b00} ^ MEM_PATTERN;
    if (ref_bytes.exists(a)) return ref_bytes[a];
    return w[8*a[1:0] +: 8];
  endfunction

  function automatic line_t ref_line(input addr_t a);
    line_t l;
    for (int b = 0; b < 16; b++) l[8*b +: 8] = ref_byte(addr_t'(a + b));
    return l;
  endfunction

  function automatic word_t ref_word(input addr_t a);
    word_t w;
    for (int b = 0; b < 4; b++) w[8*b +: 8] = ref_byte(addr_t'({a[31:2], 2'b00} + b));
    return w;
  endfunction

  task automatic apply_store(input addr_t a, input req_size_e size, input word_t data);
    int    n;
    addr_t base;
    n    = (size == SZ_BYTE) ? 1 : ((size == SZ_HALF) ? 2 : 4);
    base = a & ~addr_t'(n - 1);
    for (int b = 0; b < n; b++) ref_bytes[addr_t'(base + b)] = data[8*b +: 8];
  endtask

  // Lowest invalid way first, then follow the tree toward the older side
  function automatic int pick_victim(input int s);
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (!c_valid[s][w]) return w;
    end
    if (c_tree[s][0]) return c_tree[s][2] ? 3 : 2;
    return c_tree[s][1] ? 1 : 0;
  endfunction

  task automatic touch_way(input int s, input int w);
    c_tree[s][0] = (w < 2);
    if (w < 2) c_tree[s][1] = (w == 0);
    else c_tree[s][2] = (w == 2);
  endtask

  // ======================================================================
  // Cycle driver with the memory model
  // ======================================================================
  task automatic check_mem_request();
    if (exp_wb) begin
      check_bit("mem_req_we_o", mem_req_we_o, 1'b1);
      check_addr("mem_req_addr_o", mem_req_addr_o, exp_wb_addr);
      check_line("mem_req_wdata_o", mem_req_wdata_o, exp_wb_line);
      exp_wb = 1'b0;
    end else if (exp_fill) begin
      check_bit("mem_req_we_o", mem_req_we_o, 1'b0);
      check_addr("mem_req_addr_o", mem_req_addr_o, exp_fill_addr);
      exp_fill = 1'b0;
    end else begin
      fail_now("Memory request raised while no write-back or fill was expected");
    end
  endtask

  task automatic step(input logic valid, input addr_t addr, input logic we,
                      input req_size_e size, input word_t wdata);
    @(negedge clk_i);
    req_valid_i     = valid;
    req_addr_i      = addr;
    req_we_i        = we;
    req_size_i      = size;
    req_wdata_i     = wdata;
    mem_req_ready_i = 1'b0;
    mem_res_valid_i = 1'b0;
    if (mphase == M_IDLE && mem_req_valid_o) begin
      check_mem_request();
      m_we    = mem_req_we_o;
      m_addr  = mem_req_addr_o;
      m_wdata = mem_req_wdata_o;
      mcount  = $urandom % 7;
      mphase  = M_ACCEPT;
    end
    if (mphase == M_ACCEPT) begin
      // Held steady until the memory takes it
      check_bit("mem_req_valid_o", mem_req_valid_o, 1'b1);
      check_bit("mem_req_we_o", mem_req_we_o, m_we);
      check_addr("mem_req_addr_o", mem_req_addr_o, m_addr);
      check_line("mem_req_wdata_o", mem_req_wdata_o, m_wdata);
      if (mcount == 0) begin
        mem_req_ready_i = 1'b1;
        mcount          = $urandom % 7;
        mphase          = M_RESPOND;
      end else begin
        mcount--;
      end
    end else if (mphase == M_RESPOND) begin
      // One transaction outstanding at a time
      check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
      if (mcount == 0) begin
        mem_res_valid_i = 1'b1;
        mphase          = M_IDLE;
        if (m_we) begin
          for (int w = 0; w < 4; w++) mem_words[addr_t'(m_addr + 4*w)] = m_wdata[32*w +: 32];
        end else begin
          mem_res_rdata_i = read_line(m_addr);
        end
      end else begin
        mcount--;
      end
    end
    #1;
  endtask

  task automatic idle_step();
    step(1'b0, '0, 1'b0, SZ_WORD, '0);
  endtask

  task automatic run_access(input logic we, input req_size_e size, input addr_t addr,
                            input word_t wdata);
    int   s;
    int   way;
    int   waited;
    tag_t tag;
    logic hit;
    s   = addr[IDX_W+OFF_W-1:OFF_W];
    tag = addr[`DC_XLEN-1:IDX_W+OFF_W];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (c_valid[s][w] && c_tag[s][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      way           = pick_victim(s);
      exp_wb        = c_valid[s][way] && c_dirty[s][way];
      exp_wb_addr   = {c_tag[s][way], idx_t'(s), {OFF_W{1'b0}}};
      exp_wb_line   = ref_line(exp_wb_addr);
      exp_fill      = 1'b1;
      exp_fill_addr = {addr[`DC_XLEN-1:OFF_W], {OFF_W{1'b0}}};
    end
    step(1'b1, addr, we, size, wdata);
    waited = 0;
    while (!req_ready_o) begin
      if (waited == REQ_TIMEOUT) fail_now("Timed out waiting for the cache to take a request");
      waited++;
      step(1'b1, addr, we, size, wdata);
    end
    idle_step();
    if (hit) begin
      check_bit("res_valid_o", res_valid_o, 1'b1);
      check_bit("req_ready_o", req_ready_o, 1'b1);
    end else begin
      check_bit("res_valid_o", res_valid_o, 1'b0);
      check_bit("req_ready_o", req_ready_o, 1'b0);
      waited = 0;
      while (!res_valid_o) begin
        if (waited == RSP_TIMEOUT) fail_now("Timed out waiting for a miss response");
        waited++;
        idle_step();
      end
      // Response lands with the fill data, after any write-back
      check_bit("mem_res_valid_i", mem_res_valid_i, 1'b1);
      check_bit("req_ready_o", req_ready_o, 1'b1);
      check_bit("write-back outstanding", exp_wb, 1'b0);
      check_bit("fill outstanding", exp_fill, 1'b0);
    end
    check_bit("res_miss_o", res_miss_o, !hit);
    if (we) apply_store(addr, size, wdata);
    check_word("res_data_o", res_data_o, ref_word(addr));
    if (!hit) begin
      c_valid[s][way] = 1'b1;
      c_tag[s][way]   = tag;
      c_dirty[s][way] = we;
    end else if (we) begin
      c_dirty[s][way] = 1'b1;
    end
    touch_way(s, way);
    // Exactly one response per request
    idle_step();
    check_bit("res_valid_o", res_valid_o, 1'b0);
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    void'($urandom(32'h8a4de3fa));
    for (int i = 0; i < MAX_ACC; i++) acc_mem[i] = '1;
    $readmemh("dcache_input.txt", acc_mem);
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_addr_i      = '0;
    req_we_i        = 1'b0;
    req_size_i      = SZ_WORD;
    req_wdata_i     = '0;
    mem_req_ready_i = 1'b0;
    mem_res_valid_i = 1'b0;
    mem_res_rdata_i = '0;
    mphase          = M_IDLE;
    exp_wb          = 1'b0;
    exp_fill        = 1'b0;
    for (int s = 0; s < `DC_NUM_SET; s++) begin
      c_tree[s] = '0;
      for (int w = 0; w < `DC_NUM_WAY; w++) begin
        c_valid[s][w] = 1'b0;
        c_dirty[s][w] = 1'b0;
        c_tag[s][w]   = '0;
      end
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // Set sweep keeps every handshake low
    for (int i = 0; i < `DC_NUM_SET; i++) begin
      check_bit("req_ready_o", req_ready_o, 1'b0);
      check_bit("res_valid_o", res_valid_o, 1'b0);
      check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
      idle_step();
    end
    check_bit("req_ready_o", req_ready_o, 1'b1);
    n_acc = 0;
    while (n_acc < MAX_ACC && acc_mem[n_acc][71:68] != 4'hf) begin
      run_access(acc_mem[n_acc][68], req_size_e'(acc_mem[n_acc][65:64]),
                 acc_mem[n_acc][63:32], acc_mem[n_acc][31:0]);
      n_acc++;
    end
    if (n_acc == 0) fail_now("No accesses were read from dcache_input.txt");
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* dcache_input.txt */
// op_size_address_data: op 0 load, 1 store; size 0 byte, 1 half, 2 word
// Sets 0 and 5 receive more tags than ways so dirty lines get evicted
0_2_00000000_00000000
0_2_00000000_00000000
1_0_00000001_000000ab
0_2_00000000_00000000
1_1_00000086_00001234
1_2_00000108_cafef00d
0_0_00000185_00000000
0_2_00000204_00000000
1_0_0000028f_00000077
0_2_00000084_00000000
0_2_0000000c_00000000
0_1_0000010a_00000000
1_2_00000300_0badc0de
0_2_00000188_00000000
0_2_00000000_00000000
0_2_00000108_00000000
0_2_00000284_00000000
1_2_00000050_11223344
1_1_000000d6_0000beef
0_2_00000154_00000000
1_0_000001db_0000005c
1_2_00000258_89abcdef
0_0_000002d3_00000000
1_1_00000352_00007e7e
0_2_00000050_00000000
0_2_000000d4_00000000
0_2_000001d8_00000000
0_2_00000258_00000000
1_2_00000020_a5a5a5a5
0_2_00000024_00000000
1_0_00000073_000000e1
0_2_00000070_00000000
0_2_00000350_00000000
0_2_0000028c_00000000
0_2_00000304_00000000
0_2_00000004_00000000

/* filelist.f */
+incdir+.
dcache_pkg.sv
dcache_sram.sv
dcache_plru.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv
